/* verilog/ttc_pkg.sv */
//------------------------------------------------------------
// TTC lite shared definitions
// Bus widths, register map, bit positions, event order
//------------------------------------------------------------
`default_nettype none

package ttc_pkg;

  //------------------------------------------------------------
  // Widths
  //------------------------------------------------------------
  typedef logic [7:0]  addr_t;        // APB address
  typedef logic [31:0] data_t;        // APB data word
  typedef logic [5:0]  intr_vec_t;    // Interrupt, enable, event vector
  typedef logic [3:0]  prescale_t;    // Prescale exponent
  typedef logic [15:0] presc_div_t;   // Prescale divider, covers 2^16

  //------------------------------------------------------------
  // Register map
  //------------------------------------------------------------
  localparam addr_t ADDR_CLK_CTRL  = 8'h00;
  localparam addr_t ADDR_CNT_CTRL  = 8'h0C;
  localparam addr_t ADDR_CNT_VALUE = 8'h18;   // Read only
  localparam addr_t ADDR_INTERVAL  = 8'h24;
  localparam addr_t ADDR_MATCH1    = 8'h30;
  localparam addr_t ADDR_MATCH2    = 8'h3C;
  localparam addr_t ADDR_MATCH3    = 8'h48;
  localparam addr_t ADDR_INTR      = 8'h54;   // Clear on read
  localparam addr_t ADDR_INTR_EN   = 8'h60;

  // Clock control fields
  localparam int CLK_PRESCALE_EN  = 0;
  localparam int CLK_PRESCALE_LSB = 1;
  localparam int CLK_PRESCALE_MSB = 4;

  // Counter control fields
  localparam int CNT_DISABLE  = 0;
  localparam int CNT_INTERVAL = 1;
  localparam int CNT_MATCH_EN = 3;
  localparam int CNT_RESTART  = 4;            // Self clearing

  // Event and interrupt bit order
  localparam int INTR_INTERVAL = 0;
  localparam int INTR_MATCH1   = 1;
  localparam int INTR_MATCH2   = 2;
  localparam int INTR_MATCH3   = 3;
  localparam int INTR_OVERFLOW = 4;
  localparam int INTR_RESERVED = 5;           // Always zero

  localparam intr_vec_t INTR_VALID_MASK = 6'b01_1111;

endpackage

`default_nettype wire

/* verilog/ttc_event_if.sv */
//------------------------------------------------------------
// TTC lite counter event lines, counter to interrupt block
//------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

interface ttc_event_if;

  logic       interval_intr;    // Count equals interval, interval mode
  logic [3:1] match_intr;       // Count equals match value
  logic       overflow_intr;    // Count all ones, free running

  // Counter side
  modport source (
    output interval_intr,
    output match_intr,
    output overflow_intr
  );

  // Interrupt block side
  modport sink (
    input interval_intr,
    input match_intr,
    input overflow_intr
  );

endinterface

`default_nettype wire

/* verilog/ttc_regs.sv */
//------------------------------------------------------------
// TTC lite register block
// APB decode, control registers, read mux and strobes
//------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module ttc_regs #(
  parameter int CNT_WIDTH = 16
) (
  input  wire logic                  pclk1,
  input  wire logic                  n_p_reset1,

  // APB slave
  input  wire logic                  psel,
  input  wire logic                  penable,
  input  wire logic                  pwrite,
  input  wire ttc_pkg::addr_t        paddr,
  input  wire ttc_pkg::data_t        pwdata,
  output ttc_pkg::data_t             prdata,

  // Counter control
  output logic                       cnt_disable,
  output logic                       interval_mode,
  output logic                       match_en,
  output logic                       prescale_en,
  output ttc_pkg::prescale_t         prescale_val,
  output logic [CNT_WIDTH-1:0]       interval_val,
  output logic [CNT_WIDTH-1:0]       match1_val,
  output logic [CNT_WIDTH-1:0]       match2_val,
  output logic [CNT_WIDTH-1:0]       match3_val,
  output logic                       restart,       // One cycle pulse

  // Interrupt block
  output logic                       intr_en_reg_sel,
  output logic                       clear_interrupt,

  // Readback
  input  wire logic [CNT_WIDTH-1:0]  count_value,
  input  wire ttc_pkg::intr_vec_t    interrupt_reg_out,
  input  wire ttc_pkg::intr_vec_t    interrupt_en_out
);

  logic access;   // Access phase
  logic wr_en;    // Write in access phase
  logic rd_en;    // Read in access phase

  assign access = psel & penable;
  assign wr_en  = access & pwrite;
  assign rd_en  = access & ~pwrite;

  // Strobes, valid for the access cycle only
  assign intr_en_reg_sel = wr_en & (paddr == ttc_pkg::ADDR_INTR_EN);
  assign clear_interrupt = rd_en & (paddr == ttc_pkg::ADDR_INTR);

  //------------------------------------------------------------
  // Register file
  //------------------------------------------------------------
  always_ff @(posedge pclk1 or negedge n_p_reset1)
  begin
    if (!n_p_reset1)
    begin
      prescale_en   <= 1'b0;
      prescale_val  <= '0;
      cnt_disable   <= 1'b0;
      interval_mode <= 1'b0;
      match_en      <= 1'b0;
      restart       <= 1'b0;
      interval_val  <= '0;
      match1_val    <= '0;
      match2_val    <= '0;
      match3_val    <= '0;
    end
    else
    begin
      restart <= 1'b0;                 // Pulse default
      if (wr_en)
      begin
        case (paddr)
          ttc_pkg::ADDR_CLK_CTRL:
          begin
            prescale_en  <= pwdata[ttc_pkg::CLK_PRESCALE_EN];
            prescale_val <= pwdata[ttc_pkg::CLK_PRESCALE_MSB:ttc_pkg::CLK_PRESCALE_LSB];
          end
          ttc_pkg::ADDR_CNT_CTRL:
          begin
            cnt_disable   <= pwdata[ttc_pkg::CNT_DISABLE];
            interval_mode <= pwdata[ttc_pkg::CNT_INTERVAL];
            match_en      <= pwdata[ttc_pkg::CNT_MATCH_EN];
            restart       <= pwdata[ttc_pkg::CNT_RESTART];   // Not stored
          end
          ttc_pkg::ADDR_INTERVAL: interval_val <= pwdata[CNT_WIDTH-1:0];
          ttc_pkg::ADDR_MATCH1:   match1_val   <= pwdata[CNT_WIDTH-1:0];
          ttc_pkg::ADDR_MATCH2:   match2_val   <= pwdata[CNT_WIDTH-1:0];
          ttc_pkg::ADDR_MATCH3:   match3_val   <= pwdata[CNT_WIDTH-1:0];
          default: ;                   // Enable reg lives in interrupt block
        endcase
      end
    end
  end

  //------------------------------------------------------------
  // Read mux
  //------------------------------------------------------------
  always_comb
  begin
    prdata = '0;                       // Zero outside access phase
    if (access)
    begin
      case (paddr)
        ttc_pkg::ADDR_CLK_CTRL:
        begin
          prdata[ttc_pkg::CLK_PRESCALE_EN] = prescale_en;
          prdata[ttc_pkg::CLK_PRESCALE_MSB:ttc_pkg::CLK_PRESCALE_LSB] = prescale_val;
        end
        ttc_pkg::ADDR_CNT_CTRL:
        begin
          prdata[ttc_pkg::CNT_DISABLE]  = cnt_disable;
          prdata[ttc_pkg::CNT_INTERVAL] = interval_mode;
          prdata[ttc_pkg::CNT_MATCH_EN] = match_en;  // Restart reads 0
        end
        ttc_pkg::ADDR_CNT_VALUE: prdata = ttc_pkg::data_t'(count_value);
        ttc_pkg::ADDR_INTERVAL:  prdata = ttc_pkg::data_t'(interval_val);
        ttc_pkg::ADDR_MATCH1:    prdata = ttc_pkg::data_t'(match1_val);
        ttc_pkg::ADDR_MATCH2:    prdata = ttc_pkg::data_t'(match2_val);
        ttc_pkg::ADDR_MATCH3:    prdata = ttc_pkg::data_t'(match3_val);
        ttc_pkg::ADDR_INTR:      prdata = ttc_pkg::data_t'(interrupt_reg_out); // Pre clear
        ttc_pkg::ADDR_INTR_EN:   prdata = ttc_pkg::data_t'(interrupt_en_out);
        default:                 prdata = '0;
      endcase
    end
  end

  //------------------------------------------------------------
  // Checks
  //------------------------------------------------------------
  // Restart is a single cycle pulse
  a_restart_pulse: assert property (
    @(posedge pclk1) disable iff (!n_p_reset1)
    restart |=> !restart
  );

endmodule

`default_nettype wire

/* verilog/ttc_counter.sv */
//------------------------------------------------------------
// TTC lite counter datapath
// Prescaler, up counter, interval and match compare
//------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module ttc_counter #(
  parameter int CNT_WIDTH = 16
) (
  input  wire logic                  pclk1,
  input  wire logic                  n_p_reset1,

  // Control from register block
  input  wire logic                  cnt_disable,
  input  wire logic                  interval_mode,
  input  wire logic                  match_en,
  input  wire logic                  prescale_en,
  input  wire ttc_pkg::prescale_t    prescale_val,
  input  wire logic [CNT_WIDTH-1:0]  interval_val,
  input  wire logic [CNT_WIDTH-1:0]  match1_val,
  input  wire logic [CNT_WIDTH-1:0]  match2_val,
  input  wire logic [CNT_WIDTH-1:0]  match3_val,
  input  wire logic                  restart,

  // Status
  output logic [CNT_WIDTH-1:0]       count_value,
  ttc_event_if.source                events
);

  ttc_pkg::presc_div_t presc_div;    // Free running divider
  ttc_pkg::presc_div_t presc_mask;   // Low N+1 bits set
  logic                tick;         // Counter advance enable
  logic                at_interval;  // Count at interval limit

  //------------------------------------------------------------
  // Prescaler
  //------------------------------------------------------------
  // 2 << N minus one, wide enough for N = 15
  assign presc_mask = ttc_pkg::presc_div_t'((17'd2 << prescale_val) - 17'd1);

  // Tick once every 2^(N+1) cycles, else every cycle
  assign tick = prescale_en ? (&(presc_div | ~presc_mask)) : 1'b1;

  always_ff @(posedge pclk1 or negedge n_p_reset1)
  begin
    if (!n_p_reset1)
      presc_div <= '0;
    else if (restart)
      presc_div <= '0;                // Realign with counter
    else
      presc_div <= presc_div + 1'b1;
  end

  //------------------------------------------------------------
  // Counter
  //------------------------------------------------------------
  assign at_interval = (count_value == interval_val);

  always_ff @(posedge pclk1 or negedge n_p_reset1)
  begin
    if (!n_p_reset1)
      count_value <= '0;
    else if (restart)
      count_value <= '0;
    else if (tick && !cnt_disable)
    begin
      if (interval_mode && at_interval)
        count_value <= '0;            // Interval wrap
      else
        count_value <= count_value + 1'b1;   // Natural overflow wrap
    end
  end

  //------------------------------------------------------------
  // Event levels
  //------------------------------------------------------------
  // Held while the condition holds, also when disabled
  assign events.interval_intr = interval_mode & at_interval;
  assign events.overflow_intr = ~interval_mode & (&count_value);
  assign events.match_intr    = {match_en & (count_value == match3_val),
                                 match_en & (count_value == match2_val),
                                 match_en & (count_value == match1_val)};

  //------------------------------------------------------------
  // Checks
  //------------------------------------------------------------
  // Count never runs past the interval limit
  a_interval_wrap: assert property (
    @(posedge pclk1) disable iff (!n_p_reset1)
    (interval_mode && !cnt_disable && at_interval)
      |=> (count_value <= $past(interval_val))
  );

endmodule

`default_nettype wire

/* verilog/ttc_interrupt.sv */
//------------------------------------------------------------
// TTC lite interrupt block
// Edge capture of counter events, enable mask, clear on read
//------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module ttc_interrupt (
  input  wire logic                pclk1,
  input  wire logic                n_p_reset1,
  input  wire ttc_pkg::intr_vec_t  pwdata_en,        // Low six data bits
  input  wire logic                intr_en_reg_sel,  // Enable write strobe
  input  wire logic                clear_interrupt,  // Intr read strobe
  ttc_event_if.sink                events,
  output logic                     interrupt,
  output ttc_pkg::intr_vec_t       interrupt_reg_out,
  output ttc_pkg::intr_vec_t       interrupt_en_out
);

  ttc_pkg::intr_vec_t intr_detect;       // Current event levels
  ttc_pkg::intr_vec_t int_sync_reg;      // Levels one cycle ago
  ttc_pkg::intr_vec_t int_cycle_reg;     // Rising edges, one shot
  ttc_pkg::intr_vec_t interrupt_reg;
  ttc_pkg::intr_vec_t interrupt_en_reg;
  logic               interrupt_set;     // Capture last cycle, hold off clear

  always_comb
  begin
    intr_detect = '0;                    // Reserved bit low
    intr_detect[ttc_pkg::INTR_INTERVAL] = events.interval_intr;
    intr_detect[ttc_pkg::INTR_MATCH1]   = events.match_intr[1];
    intr_detect[ttc_pkg::INTR_MATCH2]   = events.match_intr[2];
    intr_detect[ttc_pkg::INTR_MATCH3]   = events.match_intr[3];
    intr_detect[ttc_pkg::INTR_OVERFLOW] = events.overflow_intr;
  end

  assign interrupt         = |interrupt_reg;
  assign interrupt_reg_out = interrupt_reg;
  assign interrupt_en_out  = interrupt_en_reg;

  //------------------------------------------------------------
  // Edge capture and interrupt register
  //------------------------------------------------------------
  always_ff @(posedge pclk1 or negedge n_p_reset1)
  begin
    if (!n_p_reset1)
    begin
      int_sync_reg  <= '0;
      int_cycle_reg <= '0;
      interrupt_reg <= '0;
      interrupt_set <= 1'b0;
    end
    else
    begin
      int_sync_reg  <= intr_detect;
      int_cycle_reg <= intr_detect & ~int_sync_reg;   // Rising only
      interrupt_set <= |int_cycle_reg;
      // New captures survive a clear in the same cycle
      if (clear_interrupt && !interrupt_set)
        interrupt_reg <= int_cycle_reg & interrupt_en_reg;
      else
        interrupt_reg <= interrupt_reg | (int_cycle_reg & interrupt_en_reg);
    end
  end

  // Enable register, reserved bit masked
  always_ff @(posedge pclk1 or negedge n_p_reset1)
  begin
    if (!n_p_reset1)
      interrupt_en_reg <= '0;
    else if (intr_en_reg_sel)
      interrupt_en_reg <= pwdata_en & ttc_pkg::INTR_VALID_MASK;
  end

  //------------------------------------------------------------
  // Checks
  //------------------------------------------------------------
  // Masked events never reach the register
  a_set_needs_enable: assert property (
    @(posedge pclk1) disable iff (!n_p_reset1)
    ((interrupt_reg & ~$past(interrupt_reg) & ~$past(interrupt_en_reg)) == '0)
  );

  a_reserved_zero: assert property (
    @(posedge pclk1) disable iff (!n_p_reset1)
    !interrupt_reg[ttc_pkg::INTR_RESERVED]
  );

endmodule

`default_nettype wire

/* verilog/ttc_lite.sv */
//------------------------------------------------------------
// TTC lite top level, single channel timer on APB
//------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module ttc_lite #(
  parameter int CNT_WIDTH = 16          // 8, 16 or 32
) (
  input  wire logic            pclk1,
  input  wire logic            n_p_reset1,
  input  wire logic            psel,
  input  wire logic            penable,
  input  wire logic            pwrite,
  input  wire ttc_pkg::addr_t  paddr,
  input  wire ttc_pkg::data_t  pwdata,
  output ttc_pkg::data_t       prdata,
  output logic                 interrupt
);

  // Register block to counter
  logic                 cnt_disable;
  logic                 interval_mode;
  logic                 match_en;
  logic                 prescale_en;
  ttc_pkg::prescale_t   prescale_val;
  logic [CNT_WIDTH-1:0] interval_val;
  logic [CNT_WIDTH-1:0] match1_val;
  logic [CNT_WIDTH-1:0] match2_val;
  logic [CNT_WIDTH-1:0] match3_val;
  logic                 restart;
  logic [CNT_WIDTH-1:0] count_value;

  // Register block to interrupt block
  logic                 intr_en_reg_sel;
  logic                 clear_interrupt;
  ttc_pkg::intr_vec_t   interrupt_reg_out;
  ttc_pkg::intr_vec_t   interrupt_en_out;

  ttc_event_if i_events ();              // Counter event levels

  ttc_regs #(
    .CNT_WIDTH (CNT_WIDTH)
  ) i_regs (
    .pclk1             (pclk1),
    .n_p_reset1        (n_p_reset1),
    .psel              (psel),
    .penable           (penable),
    .pwrite            (pwrite),
    .paddr             (paddr),
    .pwdata            (pwdata),
    .prdata            (prdata),
    .cnt_disable       (cnt_disable),
    .interval_mode     (interval_mode),
    .match_en          (match_en),
    .prescale_en       (prescale_en),
    .prescale_val      (prescale_val),
    .interval_val      (interval_val),
    .match1_val        (match1_val),
    .match2_val        (match2_val),
    .match3_val        (match3_val),
    .restart           (restart),
    .intr_en_reg_sel   (intr_en_reg_sel),
    .clear_interrupt   (clear_interrupt),
    .count_value       (count_value),
    .interrupt_reg_out (interrupt_reg_out),
    .interrupt_en_out  (interrupt_en_out)
  );

  ttc_counter #(
    .CNT_WIDTH (CNT_WIDTH)
  ) i_counter (
    .pclk1         (pclk1),
    .n_p_reset1    (n_p_reset1),
    .cnt_disable   (cnt_disable),
    .interval_mode (interval_mode),
    .match_en      (match_en),
    .prescale_en   (prescale_en),
    .prescale_val  (prescale_val),
    .interval_val  (interval_val),
    .match1_val    (match1_val),
    .match2_val    (match2_val),
    .match3_val    (match3_val),
    .restart       (restart),
    .count_value   (count_value),
    .events        (i_events.source)
  );

  ttc_interrupt i_interrupt (
    .pclk1             (pclk1),
    .n_p_reset1        (n_p_reset1),
    .pwdata_en         (pwdata[5:0]),    // Enable write data
    .intr_en_reg_sel   (intr_en_reg_sel),
    .clear_interrupt   (clear_interrupt),
    .events            (i_events.sink),
    .interrupt         (interrupt),
    .interrupt_reg_out (interrupt_reg_out),
    .interrupt_en_out  (interrupt_en_out)
  );

endmodule

`default_nettype wire

/* bench/tb_ttc_lite.sv */
//------------------------------------------------------------
// TTC lite testbench
// APB stimulus, reference checks on bus reads and interrupt
//------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module tb_ttc_lite;

  localparam int CNT_WIDTH  = 16;
  localparam int CLK_PERIOD = 100;                // ns
  localparam int OVF_CYCLES = 2 ** CNT_WIDTH;     // Full count wrap
  // Test lengths in cycles, watchdog is their sum plus margin
  localparam int WATCHDOG_CYCLES = 16 + 100 + 300 + 800 + (OVF_CYCLES + 200) + 600 + 1000;

  localparam int CHK_NONE = 0;   // No check on this read
  localparam int CHK_EQ   = 1;   // Exact value
  localparam int CHK_LE   = 2;   // Upper bound

  logic               pclk1;
  logic               n_p_reset1;
  logic               psel;
  logic               penable;
  logic               pwrite;
  ttc_pkg::addr_t     paddr;
  ttc_pkg::data_t     pwdata;
  ttc_pkg::data_t     prdata;
  logic               interrupt;
  logic               rd_access;

  // Reference model state
  int                 chk_kind;     // Check applied to the current read
  ttc_pkg::data_t     chk_val;      // Expected value or bound
  ttc_pkg::intr_vec_t intr_allow;   // Bits allowed in interrupt reg
  logic               intr_quiet;   // Interrupt must stay low
  int                 cyc;          // Rising edges seen
  int                 restart_cyc;  // Edge of last restart
  int                 err_count;
  int                 test_errs;
  int                 tests_passed;
  int                 tests_failed;
  logic [15:0]        lfsr_state;

  ttc_lite #(
    .CNT_WIDTH (CNT_WIDTH)
  ) i_ttc_lite (
    .pclk1      (pclk1),
    .n_p_reset1 (n_p_reset1),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .interrupt  (interrupt)
  );

  assign rd_access = psel & penable & ~pwrite;

  always #(CLK_PERIOD / 2) pclk1 = ~pclk1;

  always @(posedge pclk1)
    cyc <= cyc + 1;

  //------------------------------------------------------------
  // Checks
  //------------------------------------------------------------
  a_read_eq: assert property (@(posedge pclk1) disable iff (!n_p_reset1)
    (rd_access && chk_kind == CHK_EQ) |-> (prdata == chk_val))
  else
  begin
    err_count++;
    $display("error at %0d ns: read of 0x%02h returned 0x%08h, expected 0x%08h",
             $time, $sampled(paddr), $sampled(prdata), $sampled(chk_val));
  end

  a_read_le: assert property (@(posedge pclk1) disable iff (!n_p_reset1)
    (rd_access && chk_kind == CHK_LE) |-> (prdata <= chk_val))
  else
  begin
    err_count++;
    $display("error at %0d ns: read of 0x%02h returned 0x%08h, above bound 0x%08h",
             $time, $sampled(paddr), $sampled(prdata), $sampled(chk_val));
  end

  // Only enabled bits, never the reserved bit
  a_intr_mask: assert property (@(posedge pclk1) disable iff (!n_p_reset1)
    (rd_access && paddr == ttc_pkg::ADDR_INTR)
      |-> ((prdata & ~ttc_pkg::data_t'(intr_allow)) == '0 && !prdata[5]))
  else
  begin
    err_count++;
    $display("error at %0d ns: interrupt reg 0x%08h has bits outside 0x%02h",
             $time, $sampled(prdata), $sampled(intr_allow));
  end

  a_intr_quiet: assert property (@(posedge pclk1) disable iff (!n_p_reset1)
    intr_quiet |-> !interrupt)
  else
  begin
    err_count++;
    $display("error at %0d ns: interrupt high while no event is pending", $time);
  end

  a_prdata_idle: assert property (@(posedge pclk1) disable iff (!n_p_reset1)
    !(psel && penable) |-> (prdata == '0))
  else
  begin
    err_count++;
    $display("error at %0d ns: prdata 0x%08h outside access phase",
             $time, $sampled(prdata));
  end

  //------------------------------------------------------------
  // Helpers
  //------------------------------------------------------------
  // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    lfsr_step = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic draw_bits(input int n, output int r);
    r = 0;
    for (int i = 0; i < n; i++)
    begin
      r = (r << 1) | int'(lfsr_state[0]);
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  task automatic pick_limit(output int v);   // 6 to 40
    int b;
    draw_bits(6, b);
    v = 6 + (b % 35);
  endtask

  task automatic idle(input int n);
    repeat (n) @(negedge pclk1);
  endtask

  // Called and returns on a falling edge
  task automatic write_reg(input ttc_pkg::addr_t a, input ttc_pkg::data_t d);
    psel    = 1'b1;
    pwrite  = 1'b1;
    penable = 1'b0;
    paddr   = a;
    pwdata  = d;
    @(negedge pclk1);
    penable = 1'b1;
    @(negedge pclk1);                 // Write landed on the edge before
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    if (a == ttc_pkg::ADDR_CNT_CTRL && d[ttc_pkg::CNT_RESTART])
      restart_cyc = cyc;
  endtask

  task automatic read_reg(input ttc_pkg::addr_t a, input int kind,
                          input ttc_pkg::data_t val, output ttc_pkg::data_t d);
    chk_kind = kind;
    chk_val  = val;
    psel     = 1'b1;
    pwrite   = 1'b0;
    penable  = 1'b0;
    paddr    = a;
    @(negedge pclk1);
    penable  = 1'b1;
    #(CLK_PERIOD / 4) d = prdata;     // Settled, before the edge
    @(negedge pclk1);
    psel     = 1'b0;
    penable  = 1'b0;
    chk_kind = CHK_NONE;
  endtask

  task automatic write_check(input ttc_pkg::addr_t a, input ttc_pkg::data_t d,
                             input ttc_pkg::data_t exp);
    ttc_pkg::data_t r;
    write_reg(a, d);
    read_reg(a, CHK_EQ, exp, r);
  endtask

  task automatic wait_interrupt(input int max_cycles);
    int n;
    n = 0;
    while (!interrupt && n < max_cycles)
    begin
      @(negedge pclk1);
      n++;
    end
    if (!interrupt)
    begin
      err_count++;
      $display("Interrupt did not rise within %0d cycles, at %0d ns", max_cycles, $time);
    end
  endtask

  task automatic close_test(input int num, input string name);
    if (err_count == test_errs)
    begin
      tests_passed++;
      $display("test %0d %s: pass", num, name);
    end
    else
    begin
      tests_failed++;
      $display("error at %0d ns: test %0d %s failed with %0d errors",
               $time, num, name, err_count - test_errs);
    end
    test_errs = err_count;
  endtask

  //------------------------------------------------------------
  // Watchdog
  //------------------------------------------------------------
  initial
  begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Test FAILED");
    $finish;
  end

  //------------------------------------------------------------
  // Stimulus
  //------------------------------------------------------------
  initial
  begin
    ttc_pkg::data_t r;
    ttc_pkg::data_t c1;
    int             v;
    int             m;
    int             n;
    pclk1 = 1'b0;
    n_p_reset1 = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    chk_kind = CHK_NONE;
    chk_val = '0;
    intr_allow = '0;
    intr_quiet = 1'b1;
    cyc = 0;
    restart_cyc = 0;
    err_count = 0;
    test_errs = 0;
    tests_passed = 0;
    tests_failed = 0;
    lfsr_state = 16'd43288;
    repeat (16) @(posedge pclk1);
    @(negedge pclk1);
    n_p_reset1 = 1'b1;
    restart_cyc = cyc;                // Counter runs from reset release

    // Test 1, reset values and readback masks
    read_reg(ttc_pkg::ADDR_CLK_CTRL, CHK_EQ, '0, r);
    read_reg(ttc_pkg::ADDR_CNT_CTRL, CHK_EQ, '0, r);
    read_reg(ttc_pkg::ADDR_INTERVAL, CHK_EQ, '0, r);
    read_reg(ttc_pkg::ADDR_MATCH1, CHK_EQ, '0, r);
    read_reg(ttc_pkg::ADDR_MATCH2, CHK_EQ, '0, r);
    read_reg(ttc_pkg::ADDR_MATCH3, CHK_EQ, '0, r);
    read_reg(ttc_pkg::ADDR_INTR, CHK_EQ, '0, r);
    read_reg(ttc_pkg::ADDR_INTR_EN, CHK_EQ, '0, r);
    read_reg(ttc_pkg::ADDR_CNT_VALUE, CHK_LE, ttc_pkg::data_t'(cyc + 2 - restart_cyc), r);
    write_check(ttc_pkg::ADDR_INTERVAL, 32'hABCD_1234, 32'h0000_1234);  // 16 bit field
    write_check(ttc_pkg::ADDR_MATCH1, 32'h5A5A_00C3, 32'h0000_00C3);
    write_check(ttc_pkg::ADDR_MATCH2, 32'h0F0F_7E81, 32'h0000_7E81);
    write_check(ttc_pkg::ADDR_MATCH3, 32'hFFFF_FFFF, 32'h0000_FFFF);
    write_check(ttc_pkg::ADDR_CLK_CTRL, 32'hFFFF_FFFF, 32'h0000_001F); // Enable + N
    write_check(ttc_pkg::ADDR_INTR_EN, 32'hFFFF_FFFF, 32'h0000_001F);  // Bit 5 low
    write_check(ttc_pkg::ADDR_INTR_EN, 32'h0000_0000, 32'h0000_0000);
    write_check(ttc_pkg::ADDR_CNT_CTRL, 32'hFFFF_FFFF, 32'h0000_000B); // Restart reads 0
    write_reg(ttc_pkg::ADDR_CNT_CTRL, 32'h0000_0001);                  // Hold counter
    write_reg(ttc_pkg::ADDR_CLK_CTRL, 32'h0000_0000);
    read_reg(ttc_pkg::ADDR_INTR, CHK_EQ, '0, r);
    close_test(1, "reset and readback");

    // Test 2, interval interrupt and clear
    pick_limit(v);
    write_reg(ttc_pkg::ADDR_INTERVAL, ttc_pkg::data_t'(v));
    write_reg(ttc_pkg::ADDR_INTR_EN, 32'h0000_0001);
    intr_allow = 6'h01;
    intr_quiet = 1'b0;
    write_reg(ttc_pkg::ADDR_CNT_CTRL, 32'h0000_0012);   // Interval mode, restart
    repeat (4)
    begin
      idle(3);
      read_reg(ttc_pkg::ADDR_CNT_VALUE, CHK_LE, ttc_pkg::data_t'(v), r);
    end
    wait_interrupt(200);
    write_reg(ttc_pkg::ADDR_CNT_CTRL, 32'h0000_0003);   // Freeze, keep interval mode
    idle(4);                                            // Let pending captures settle
    read_reg(ttc_pkg::ADDR_INTR, CHK_EQ, 32'h0000_0001, r);
    intr_quiet = 1'b1;
    read_reg(ttc_pkg::ADDR_INTR, CHK_EQ, '0, r);
    close_test(2, "interval interrupt");

    // Test 3, match events with bits 1 and 3 enabled
    draw_bits(6, m);
    write_reg(ttc_pkg::ADDR_MATCH1, ttc_pkg::data_t'(m % v));
    draw_bits(6, m);
    write_reg(ttc_pkg::ADDR_MATCH2, ttc_pkg::data_t'(m % v));
    draw_bits(6, m);
    write_reg(ttc_pkg::ADDR_MATCH3, ttc_pkg::data_t'(m % v));
    write_reg(ttc_pkg::ADDR_INTR_EN, 32'h0000_000A);
    intr_allow = 6'h0A;
    intr_quiet = 1'b0;
    write_reg(ttc_pkg::ADDR_CNT_CTRL, 32'h0000_001A);   // Interval, match, restart
    repeat (3)
    begin
      wait_interrupt(200);
      write_reg(ttc_pkg::ADDR_CNT_CTRL, 32'h0000_000B); // Freeze
      idle(4);
      read_reg(ttc_pkg::ADDR_INTR, CHK_NONE, '0, r);    // Mask check only
      intr_quiet = 1'b1;
      read_reg(ttc_pkg::ADDR_INTR, CHK_EQ, '0, r);      // Emptied by the clear
      intr_quiet = 1'b0;
      write_reg(ttc_pkg::ADDR_CNT_CTRL, 32'h0000_000A); // Resume, no restart
    end
    write_reg(ttc_pkg::ADDR_CNT_CTRL, 32'h0000_0001);
    idle(4);
    read_reg(ttc_pkg::ADDR_INTR, CHK_NONE, '0, r);
    close_test(3, "match masking");

    // Test 4, free running overflow
    write_reg(ttc_pkg::ADDR_INTR_EN, 32'h0000_0010);
    intr_allow = 6'h10;
    read_reg(ttc_pkg::ADDR_INTR, CHK_EQ, '0, r);
    intr_quiet = 1'b1;
    write_reg(ttc_pkg::ADDR_CNT_CTRL, 32'h0000_0010);   // Restart, no interval
    idle(OVF_CYCLES - 16);
    read_reg(ttc_pkg::ADDR_CNT_VALUE, CHK_LE, ttc_pkg::data_t'(cyc + 2 - restart_cyc), r);
    intr_quiet = 1'b0;                                  // Wrap is close now
    wait_interrupt(64);
    read_reg(ttc_pkg::ADDR_CNT_VALUE, CHK_LE, 32'h0000_0008, r);  // Just wrapped
    read_reg(ttc_pkg::ADDR_INTR, CHK_EQ, 32'h0000_0010, r);
    write_reg(ttc_pkg::ADDR_CNT_CTRL, 32'h0000_0001);
    write_reg(ttc_pkg::ADDR_INTR_EN, 32'h0000_0000);
    idle(4);
    read_reg(ttc_pkg::ADDR_INTR, CHK_NONE, '0, r);
    intr_allow = '0;
    intr_quiet = 1'b1;
    close_test(4, "overflow");

    // Test 5, disable, restart and prescale
    read_reg(ttc_pkg::ADDR_CNT_VALUE, CHK_NONE, '0, c1);
    idle(50);
    read_reg(ttc_pkg::ADDR_CNT_VALUE, CHK_EQ, c1, r);    // Frozen while disabled
    write_reg(ttc_pkg::ADDR_CNT_CTRL, 32'h0000_0010);
    idle(20);
    read_reg(ttc_pkg::ADDR_CNT_VALUE, CHK_LE, ttc_pkg::data_t'(cyc + 2 - restart_cyc), r);
    draw_bits(2, n);
    write_reg(ttc_pkg::ADDR_CLK_CTRL, ttc_pkg::data_t'((n << 1) | 1));
    write_reg(ttc_pkg::ADDR_CNT_CTRL, 32'h0000_0010);
    idle(100);
    // One tick per 2^(N+1) cycles
    read_reg(ttc_pkg::ADDR_CNT_VALUE, CHK_LE,
             ttc_pkg::data_t'(((cyc + 2 - restart_cyc) >> (n + 1)) + 1), r);
    write_reg(ttc_pkg::ADDR_CLK_CTRL, 32'h0000_0000);
    write_reg(ttc_pkg::ADDR_CNT_CTRL, 32'h0000_0001);
    close_test(5, "disable restart prescale");

    $display("Summary: %0d tests, %0d passed, %0d failed, %0d errors",
             tests_passed + tests_failed, tests_passed, tests_failed, err_count);
    if (err_count == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* ttc_lite.f */
verilog/ttc_pkg.sv
verilog/ttc_event_if.sv
verilog/ttc_regs.sv
verilog/ttc_counter.sv
verilog/ttc_interrupt.sv
verilog/ttc_lite.sv
bench/tb_ttc_lite.sv

/* Makefile */
# Verilator build and run of the TTC lite testbench
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_ttc_lite
FILELIST  ?= ttc_lite.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then \
	  echo "Simulation reported failure, see $(LOG)"; exit 1; fi
	@if ! grep -q "Test OK" $(LOG); then \
	  echo "Simulation ended without a result, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
